// ==== hw/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // --------------------------------------------------
    // Field widths
    // --------------------------------------------------
    localparam int XLEN       = 32;
    localparam int REG_IDX_W  = 5;
    localparam int CSR_ADDR_W = 12;
    localparam int CAUSE_W    = 4;

    typedef logic [XLEN-1:0]       inst_t;
    typedef logic [XLEN-1:0]       addr_t;
    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_IDX_W-1:0]  reg_idx_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [CAUSE_W-1:0]    cause_t;

    // --------------------------------------------------
    // Major opcodes
    // --------------------------------------------------
    typedef enum logic [6:0] {
        OPC_LOAD     = 7'b0000011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_OP_IMM   = 7'b0010011,
        OPC_AUIPC    = 7'b0010111,
        OPC_STORE    = 7'b0100011,
        OPC_OP       = 7'b0110011,
        OPC_LUI      = 7'b0110111,
        OPC_BRANCH   = 7'b1100011,
        OPC_JALR     = 7'b1100111,
        OPC_JAL      = 7'b1101111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_e;

    // Arithmetic funct3
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Other families
    localparam logic [2:0] F3_JALR    = 3'b000;
    localparam logic [2:0] F3_FENCE   = 3'b000;
    localparam logic [2:0] F3_PRIV    = 3'b000;
    localparam logic [2:0] F3_CSR_RSV = 3'b100;

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

    // Privileged funct12
    localparam logic [11:0] F12_ECALL  = 12'h000;
    localparam logic [11:0] F12_EBREAK = 12'h001;
    localparam logic [11:0] F12_MRET   = 12'h302;

    // Exception causes
    localparam cause_t CAUSE_ILLEGAL = 4'd2;
    localparam cause_t CAUSE_BREAK   = 4'd3;
    localparam cause_t CAUSE_ECALL   = 4'd11;

endpackage

// ==== hw/decode_pkg.sv ====
package decode_pkg;

    import rv_isa_pkg::*;

    // --------------------------------------------------
    // Operation encoding
    // --------------------------------------------------
    typedef enum logic [3:0] {
        UNIT_NONE,
        UNIT_ALU,
        UNIT_BRANCH,
        UNIT_JUMP,
        UNIT_LOAD,
        UNIT_STORE,
        UNIT_CSR,
        UNIT_TRAP,
        UNIT_FENCE
    } unit_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_fn_e;

    typedef struct packed {
        unit_e      unit;
        alu_fn_e    alu_fn;
        // First operand is the pc
        logic       use_pc;
        logic       use_imm;
        // Branch condition, memory size or CSR operation
        logic [2:0] funct3;
        logic       is_mret;
    } op_t;

    // --------------------------------------------------
    // Decoded bundle
    // --------------------------------------------------
    typedef struct packed {
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    imm;
        op_t      op;
    } decoded_t;

    // Payload handed to execute
    typedef struct packed {
        addr_t     pc;
        decoded_t  dec;
        csr_addr_t csr_addr;
    } exec_t;

endpackage

// ==== hw/alu_decoder.sv ====
`timescale 1ns/1ps

module alu_decoder
    import rv_isa_pkg::*;
    import decode_pkg::*;
(
    input  inst_t    inst,
    output decoded_t dec,
    output logic     illegal
);

    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    function automatic alu_fn_e alu_fn_of(input logic [2:0] f3, input logic alt);
        alu_fn_e fn;
        fn = ALU_ADD;
        case (f3)
            F3_ADD:  fn = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  fn = ALU_SLL;
            F3_SLT:  fn = ALU_SLT;
            F3_SLTU: fn = ALU_SLTU;
            F3_XOR:  fn = ALU_XOR;
            F3_SR:   fn = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   fn = ALU_OR;
            F3_AND:  fn = ALU_AND;
        endcase
        return fn;
    endfunction

    always_comb begin
        dec            = '0;
        illegal        = 1'b0;
        dec.rd         = inst[11:7];
        dec.op.unit    = UNIT_ALU;
        case (opcode_e'(inst[6:0]))
            OPC_OP: begin
                dec.rs1       = inst[19:15];
                dec.rs2       = inst[24:20];
                dec.op.alu_fn = alu_fn_of(funct3, inst[30]);
                // Alternate funct7 only exists for sub and sra
                if (funct7 == FUNCT7_ALT)
                    illegal = (funct3 != F3_ADD) && (funct3 != F3_SR);
                else
                    illegal = (funct7 != FUNCT7_BASE);
            end
            OPC_OP_IMM: begin
                dec.rs1        = inst[19:15];
                dec.op.use_imm = 1'b1;
                dec.op.alu_fn  = alu_fn_of(funct3, (funct3 == F3_SR) && inst[30]);
                if (funct3 == F3_SLL || funct3 == F3_SR) begin
                    // Shift amount only
                    dec.imm = {27'b0, inst[24:20]};
                    if (funct3 == F3_SLL)
                        illegal = (funct7 != FUNCT7_BASE);
                    else
                        illegal = (funct7 != FUNCT7_BASE) && (funct7 != FUNCT7_ALT);
                end else begin
                    dec.imm = {{20{inst[31]}}, inst[31:20]};
                end
            end
            OPC_LUI: begin
                dec.imm        = {inst[31:12], 12'b0};
                dec.op.use_imm = 1'b1;
                dec.op.alu_fn  = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                dec.imm        = {inst[31:12], 12'b0};
                dec.op.use_imm = 1'b1;
                dec.op.use_pc  = 1'b1;
                dec.op.alu_fn  = ALU_ADD;
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

// ==== hw/flow_decoder.sv ====
`timescale 1ns/1ps

module flow_decoder
    import rv_isa_pkg::*;
    import decode_pkg::*;
(
    input  inst_t    inst,
    output decoded_t dec,
    output logic     illegal
);

    word_t      imm_i;
    word_t      imm_j;
    word_t      imm_b;
    logic [2:0] funct3;

    assign funct3 = inst[14:12];

    // --------------------------------------------------
    // Sign-extended offsets
    // --------------------------------------------------
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

    always_comb begin
        dec     = '0;
        illegal = 1'b0;
        case (opcode_e'(inst[6:0]))
            OPC_JAL: begin
                // Link address goes to rd, target is pc + offset
                dec.rd         = inst[11:7];
                dec.imm        = imm_j;
                dec.op.unit    = UNIT_JUMP;
                dec.op.use_pc  = 1'b1;
                dec.op.use_imm = 1'b1;
                dec.op.alu_fn  = ALU_ADD;
            end
            OPC_JALR: begin
                dec.rd         = inst[11:7];
                dec.rs1        = inst[19:15];
                dec.imm        = imm_i;
                dec.op.unit    = UNIT_JUMP;
                dec.op.use_imm = 1'b1;
                dec.op.alu_fn  = ALU_ADD;
                illegal        = (funct3 != F3_JALR);
            end
            OPC_BRANCH: begin
                dec.rs1        = inst[19:15];
                dec.rs2        = inst[24:20];
                dec.imm        = imm_b;
                dec.op.unit    = UNIT_BRANCH;
                dec.op.alu_fn  = ALU_SUB;
                dec.op.funct3  = funct3;
                // No condition is encoded at 2 and 3
                illegal        = (funct3 == 3'd2) || (funct3 == 3'd3);
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

// ==== hw/mem_decoder.sv ====
`timescale 1ns/1ps

module mem_decoder
    import rv_isa_pkg::*;
    import decode_pkg::*;
(
    input  inst_t    inst,
    output decoded_t dec,
    output logic     illegal
);

    logic [2:0] funct3;

    assign funct3 = inst[14:12];

    always_comb begin
        dec     = '0;
        illegal = 1'b0;
        case (opcode_e'(inst[6:0]))
            OPC_LOAD: begin
                dec.rd         = inst[11:7];
                dec.rs1        = inst[19:15];
                dec.imm        = {{20{inst[31]}}, inst[31:20]};
                dec.op.unit    = UNIT_LOAD;
                dec.op.use_imm = 1'b1;
                dec.op.alu_fn  = ALU_ADD;
                // Size in bits 1:0, unsigned flag in bit 2
                dec.op.funct3  = funct3;
                illegal        = (funct3 == 3'd3) || (funct3 == 3'd6) || (funct3 == 3'd7);
            end
            OPC_STORE: begin
                dec.rs1        = inst[19:15];
                dec.rs2        = inst[24:20];
                dec.imm        = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                dec.op.unit    = UNIT_STORE;
                dec.op.use_imm = 1'b1;
                dec.op.alu_fn  = ALU_ADD;
                dec.op.funct3  = funct3;
                illegal        = (funct3 > 3'd2);
            end
            OPC_MISC_MEM: begin
                // Fence runs as a no-op
                dec.op.unit = UNIT_FENCE;
                illegal     = (funct3 != F3_FENCE);
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

// ==== hw/system_decoder.sv ====
`timescale 1ns/1ps

module system_decoder
    import rv_isa_pkg::*;
    import decode_pkg::*;
(
    input  inst_t     inst,
    output decoded_t  dec,
    output csr_addr_t csr_addr,
    output logic      illegal,
    output logic      trap,
    output cause_t    cause,
    output logic      redirect
);

    logic [2:0]  funct3;
    logic [11:0] funct12;
    logic        regs_zero;

    assign funct3    = inst[14:12];
    assign funct12   = inst[31:20];
    assign regs_zero = (inst[19:15] == '0) && (inst[11:7] == '0);

    always_comb begin
        dec      = '0;
        csr_addr = '0;
        illegal  = 1'b0;
        trap     = 1'b0;
        cause    = '0;
        redirect = 1'b0;
        if (funct3 == F3_PRIV) begin
            // --------------------------------------------------
            // Privileged forms
            // --------------------------------------------------
            dec.op.unit = UNIT_TRAP;
            if (regs_zero && funct12 == F12_ECALL) begin
                trap     = 1'b1;
                cause    = CAUSE_ECALL;
                redirect = 1'b1;
            end else if (regs_zero && funct12 == F12_EBREAK) begin
                trap     = 1'b1;
                cause    = CAUSE_BREAK;
                redirect = 1'b1;
            end else if (regs_zero && funct12 == F12_MRET) begin
                dec.op.is_mret = 1'b1;
                redirect       = 1'b1;
            end else begin
                illegal = 1'b1;
                cause   = CAUSE_ILLEGAL;
            end
        end else if (funct3 == F3_CSR_RSV) begin
            illegal = 1'b1;
            cause   = CAUSE_ILLEGAL;
        end else begin
            // CSR access, bit 2 picks the zimm source
            dec.rd        = inst[11:7];
            dec.op.unit   = UNIT_CSR;
            dec.op.funct3 = funct3;
            csr_addr      = funct12;
            if (funct3[2]) begin
                dec.imm        = {27'b0, inst[19:15]};
                dec.op.use_imm = 1'b1;
            end else begin
                dec.rs1 = inst[19:15];
            end
        end
    end

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
    import rv_isa_pkg::*;
    import decode_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  logic   fetch_valid,
    input  inst_t  fetch_inst,
    input  addr_t  fetch_pc,
    output logic   fetch_ready,
    output logic   exec_valid,
    input  logic   exec_ready,
    output exec_t  exec,
    output logic   redirect,
    output logic   trap,
    output cause_t trap_cause
);

    inst_t     inst_q;
    addr_t     pc_q;
    logic      occupied;

    decoded_t  alu_dec, flow_dec, mem_dec, sys_dec, dec_sel;
    logic      alu_illegal, flow_illegal, mem_illegal, sys_illegal;
    logic      family_illegal;
    logic      is_system;
    csr_addr_t sys_csr_addr;
    logic      sys_trap;
    cause_t    sys_cause;
    logic      sys_redirect;

    // --------------------------------------------------
    // Strobes and instruction register
    // --------------------------------------------------
    assign exec_valid  = occupied;
    assign fetch_ready = ~occupied;

    always_ff @(posedge clock) begin
        if (reset) begin
            inst_q <= '0;
            pc_q   <= '0;
        end else if (fetch_valid && fetch_ready) begin
            inst_q <= fetch_inst;
            pc_q   <= fetch_pc;
        end
    end

    // One instruction held at a time
    always_ff @(posedge clock) begin
        if (reset)
            occupied <= 1'b0;
        else if (fetch_valid && fetch_ready)
            occupied <= 1'b1;
        else if (exec_valid && exec_ready)
            occupied <= 1'b0;
    end

    // --------------------------------------------------
    // Format decoders
    // --------------------------------------------------
    alu_decoder u_alu (.inst(inst_q), .dec(alu_dec), .illegal(alu_illegal));
    flow_decoder u_flow (.inst(inst_q), .dec(flow_dec), .illegal(flow_illegal));
    mem_decoder u_mem (.inst(inst_q), .dec(mem_dec), .illegal(mem_illegal));

    system_decoder u_sys (
        .inst     (inst_q),
        .dec      (sys_dec),
        .csr_addr (sys_csr_addr),
        .illegal  (sys_illegal),
        .trap     (sys_trap),
        .cause    (sys_cause),
        .redirect (sys_redirect)
    );

    always_comb begin
        dec_sel        = '0;
        family_illegal = 1'b0;
        is_system      = 1'b0;
        case (opcode_e'(inst_q[6:0]))
            OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC: begin
                dec_sel        = alu_dec;
                family_illegal = alu_illegal;
            end
            OPC_JAL, OPC_JALR, OPC_BRANCH: begin
                dec_sel        = flow_dec;
                family_illegal = flow_illegal;
            end
            OPC_LOAD, OPC_STORE, OPC_MISC_MEM: begin
                dec_sel        = mem_dec;
                family_illegal = mem_illegal;
            end
            OPC_SYSTEM: begin
                dec_sel        = sys_dec;
                family_illegal = sys_illegal;
                is_system      = 1'b1;
            end
            // Unknown opcode stays all zero
            default: family_illegal = 1'b1;
        endcase
    end

    assign exec = '{pc: pc_q, dec: dec_sel, csr_addr: is_system ? sys_csr_addr : '0};

    // --------------------------------------------------
    // Side outputs
    // --------------------------------------------------
    assign trap       = exec_valid && (family_illegal || (is_system && sys_trap));
    assign trap_cause = family_illegal ? CAUSE_ILLEGAL : (is_system ? sys_cause : '0);
    assign redirect   = exec_valid && (family_illegal || dec_sel.op.unit == UNIT_JUMP ||
                                       (is_system && sys_redirect));

    // Held instruction only leaves on a retire
    hold_until_ready: assert property (@(posedge clock) disable iff (reset)
        exec_valid && !exec_ready |=> exec_valid);

    stable_under_stall: assert property (@(posedge clock) disable iff (reset)
        exec_valid && !exec_ready |=> $stable(exec));

    trap_redirects: assert property (@(posedge clock) disable iff (reset)
        trap |-> redirect);

endmodule

// ==== hw/riscv_decode_top.sv ====
`timescale 1ns/1ps

module riscv_decode_top
    import rv_isa_pkg::*;
    import decode_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  logic   fetch_valid,
    input  inst_t  fetch_inst,
    input  addr_t  fetch_pc,
    output logic   fetch_ready,
    output logic   exec_valid,
    input  logic   exec_ready,
    output exec_t  exec,
    output logic   redirect,
    output logic   trap,
    output cause_t trap_cause
);

    decode_stage u_decode (
        .clock       (clock),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_inst  (fetch_inst),
        .fetch_pc    (fetch_pc),
        .fetch_ready (fetch_ready),
        .exec_valid  (exec_valid),
        .exec_ready  (exec_ready),
        .exec        (exec),
        .redirect    (redirect),
        .trap        (trap),
        .trap_cause  (trap_cause)
    );

endmodule

// ==== bench/decode_vectors.svh ====
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

    typedef struct packed {
        inst_t      inst;
        addr_t      pc;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        word_t      imm;
        unit_e      unit;
        // use_pc, redirect, trap
        logic [2:0] flags;
        cause_t     cause;
    } vector_t;

    localparam int NUM_VECTORS = 23;

    // --------------------------------------------------
    // inst, pc, rd, rs1, rs2, imm, unit, flags, cause
    // --------------------------------------------------
    localparam vector_t VECTORS [NUM_VECTORS] = '{
        '{32'h002081b3, 32'h100, 5'd3, 5'd1, 5'd2, 32'h00000000, UNIT_ALU, 3'b000, 4'd0},
        '{32'h407302b3, 32'h104, 5'd5, 5'd6, 5'd7, 32'h00000000, UNIT_ALU, 3'b000, 4'd0},
        // mul is outside RV32I
        '{32'h022081b3, 32'h108, 5'd3, 5'd1, 5'd2, 32'h00000000, UNIT_ALU, 3'b011, 4'd2},
        '{32'hffb58513, 32'h10c, 5'd10, 5'd11, 5'd0, 32'hfffffffb, UNIT_ALU, 3'b000, 4'd0},
        '{32'h40725213, 32'h110, 5'd4, 5'd4, 5'd0, 32'h00000007, UNIT_ALU, 3'b000, 4'd0},
        '{32'h123450b7, 32'h114, 5'd1, 5'd0, 5'd0, 32'h12345000, UNIT_ALU, 3'b000, 4'd0},
        '{32'hfffff117, 32'h118, 5'd2, 5'd0, 5'd0, 32'hfffff000, UNIT_ALU, 3'b100, 4'd0},
        // Jumps and branches
        '{32'hff9ff0ef, 32'h11c, 5'd1, 5'd0, 5'd0, 32'hfffffff8, UNIT_JUMP, 3'b110, 4'd0},
        '{32'hffc302e7, 32'h120, 5'd5, 5'd6, 5'd0, 32'hfffffffc, UNIT_JUMP, 3'b010, 4'd0},
        '{32'hfe2088e3, 32'h124, 5'd0, 5'd1, 5'd2, 32'hfffffff0, UNIT_BRANCH, 3'b000, 4'd0},
        '{32'h00419663, 32'h128, 5'd0, 5'd3, 5'd4, 32'h0000000c, UNIT_BRANCH, 3'b000, 4'd0},
        '{32'h0041a663, 32'h12c, 5'd0, 5'd3, 5'd4, 32'h0000000c, UNIT_BRANCH, 3'b011, 4'd2},
        // Memory
        '{32'hff412403, 32'h130, 5'd8, 5'd2, 5'd0, 32'hfffffff4, UNIT_LOAD, 3'b000, 4'd0},
        '{32'h00354483, 32'h134, 5'd9, 5'd10, 5'd0, 32'h00000003, UNIT_LOAD, 3'b000, 4'd0},
        '{32'h00353483, 32'h138, 5'd9, 5'd10, 5'd0, 32'h00000003, UNIT_LOAD, 3'b011, 4'd2},
        '{32'hfe532623, 32'h13c, 5'd0, 5'd6, 5'd5, 32'hffffffec, UNIT_STORE, 3'b000, 4'd0},
        '{32'h0ff0000f, 32'h140, 5'd0, 5'd0, 5'd0, 32'h00000000, UNIT_FENCE, 3'b000, 4'd0},
        // System
        '{32'h00000073, 32'h144, 5'd0, 5'd0, 5'd0, 32'h00000000, UNIT_TRAP, 3'b011, 4'd11},
        '{32'h00100073, 32'h148, 5'd0, 5'd0, 5'd0, 32'h00000000, UNIT_TRAP, 3'b011, 4'd3},
        '{32'h30200073, 32'h14c, 5'd0, 5'd0, 5'd0, 32'h00000000, UNIT_TRAP, 3'b010, 4'd0},
        '{32'h300312f3, 32'h150, 5'd5, 5'd6, 5'd0, 32'h00000000, UNIT_CSR, 3'b000, 4'd0},
        '{32'h3042e3f3, 32'h154, 5'd7, 5'd0, 5'd0, 32'h00000005, UNIT_CSR, 3'b000, 4'd0},
        // Opcode 7f does not exist
        '{32'hffffffff, 32'h158, 5'd0, 5'd0, 5'd0, 32'h00000000, UNIT_NONE, 3'b011, 4'd2}
    };

`endif

// ==== bench/decode_tb.sv ====
`timescale 1ns/1ps

module decode_tb
    import rv_isa_pkg::*;
    import decode_pkg::*;
();

    `include "decode_vectors.svh"

    localparam int WAIT_LIMIT = 20;

    logic   clock;
    logic   reset;
    logic   fetch_valid;
    inst_t  fetch_inst;
    addr_t  fetch_pc;
    logic   fetch_ready;
    logic   exec_valid;
    logic   exec_ready;
    exec_t  exec;
    logic   redirect;
    logic   trap;
    cause_t trap_cause;
    integer seed;

    riscv_decode_top u_dut (
        .clock       (clock),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_inst  (fetch_inst),
        .fetch_pc    (fetch_pc),
        .fetch_ready (fetch_ready),
        .exec_valid  (exec_valid),
        .exec_ready  (exec_ready),
        .exec        (exec),
        .redirect    (redirect),
        .trap        (trap),
        .trap_cause  (trap_cause)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // --------------------------------------------------
    // Failure handling and compare tasks
    // --------------------------------------------------
    task automatic abort_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_unit(input string name, input unit_e got, input unit_e exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %s, expected %s", $time, name, got.name(), exp.name());
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_cause(input string name, input cause_t got, input cause_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_csr(input string name, input csr_addr_t got, input csr_addr_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_payload(input string name, input exec_t got, input exec_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // --------------------------------------------------
    // Waits, sampled on the falling edge
    // --------------------------------------------------
    task automatic wait_for_fetch_ready(input int idx);
        int cycles;
        cycles = 0;
        while (!fetch_ready) begin
            if (cycles == WAIT_LIMIT) begin
                $display("Timed out waiting for fetch_ready before vector %0d", idx);
                abort_run();
            end
            @(negedge clock);
            cycles++;
        end
    endtask

    task automatic wait_for_exec_valid(input int idx);
        int cycles;
        cycles = 0;
        while (!exec_valid) begin
            if (cycles == WAIT_LIMIT) begin
                $display("Timed out waiting for exec_valid on vector %0d", idx);
                abort_run();
            end
            @(negedge clock);
            cycles++;
        end
    endtask

    task automatic compare_decode(input int idx, input vector_t v);
        csr_addr_t exp_csr;
        // Only CSR instructions carry the address from bits 31:20
        exp_csr = (v.unit == UNIT_CSR) ? v.inst[31:20] : '0;
        check_word($sformatf("vector %0d pc", idx), exec.pc, v.pc);
        check_reg($sformatf("vector %0d rd", idx), exec.dec.rd, v.rd);
        check_reg($sformatf("vector %0d rs1", idx), exec.dec.rs1, v.rs1);
        check_reg($sformatf("vector %0d rs2", idx), exec.dec.rs2, v.rs2);
        check_word($sformatf("vector %0d imm", idx), exec.dec.imm, v.imm);
        check_unit($sformatf("vector %0d unit", idx), exec.dec.op.unit, v.unit);
        check_flag($sformatf("vector %0d use_pc", idx), exec.dec.op.use_pc, v.flags[2]);
        check_flag($sformatf("vector %0d redirect", idx), redirect, v.flags[1]);
        check_flag($sformatf("vector %0d trap", idx), trap, v.flags[0]);
        check_cause($sformatf("vector %0d trap_cause", idx), trap_cause, v.cause);
        check_csr($sformatf("vector %0d csr_addr", idx), exec.csr_addr, exp_csr);
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        exec_t held;
        int    stalls;
        seed        = 16148;
        reset       = 1'b1;
        fetch_valid = 1'b0;
        fetch_inst  = '0;
        fetch_pc    = '0;
        exec_ready  = 1'b0;

        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        check_flag("exec_valid after reset", exec_valid, 1'b0);
        check_flag("fetch_ready after reset", fetch_ready, 1'b1);

        for (int i = 0; i < NUM_VECTORS; i++) begin
            wait_for_fetch_ready(i);
            fetch_valid = 1'b1;
            fetch_inst  = VECTORS[i].inst;
            fetch_pc    = VECTORS[i].pc;
            @(negedge clock);
            fetch_valid = 1'b0;
            wait_for_exec_valid(i);
            compare_decode(i, VECTORS[i]);

            // Back-pressure from execute
            held   = exec;
            stalls = $unsigned($random(seed)) % 4;
            // Fetch offers another word that the full stage must refuse
            fetch_valid = 1'b1;
            fetch_inst  = ~VECTORS[i].inst;
            fetch_pc    = ~VECTORS[i].pc;
            repeat (stalls) begin
                @(negedge clock);
                check_flag("exec_valid under stall", exec_valid, 1'b1);
                check_flag("fetch_ready under stall", fetch_ready, 1'b0);
                check_payload("exec under stall", exec, held);
            end

            exec_ready = 1'b1;
            @(negedge clock);
            exec_ready  = 1'b0;
            fetch_valid = 1'b0;
            check_flag("exec_valid after retire", exec_valid, 1'b0);
            check_flag("fetch_ready after retire", fetch_ready, 1'b1);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== riscv_decode.f ====
+incdir+bench
hw/rv_isa_pkg.sv
hw/decode_pkg.sv
hw/alu_decoder.sv
hw/flow_decoder.sv
hw/mem_decoder.sv
hw/system_decoder.sv
hw/decode_stage.sv
hw/riscv_decode_top.sv
bench/decode_tb.sv
